// ==== verilog/ppu_defs.svh ====
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// ======================================================================
// Screen and frame geometry
// ======================================================================
`define PPU_DOTS_PER_LINE   9'd456
`define PPU_LINES_PER_FRAME 8'd154
`define PPU_VISIBLE_LINES   8'd144
`define PPU_SCREEN_W        8'd160

// Mode lengths in dots, mode 0 takes the rest of the line
`define PPU_MODE2_LEN       9'd80
`define PPU_MODE3_LEN       9'd172

// ======================================================================
// CPU address map
// ======================================================================
`define PPU_VRAM_BASE       16'h8000
`define PPU_VRAM_LAST       16'h9FFF

`define PPU_REG_LCDC        16'hFF40
`define PPU_REG_SCY         16'hFF42
`define PPU_REG_SCX         16'hFF43
`define PPU_REG_LY          16'hFF44
`define PPU_REG_BGP         16'hFF47

// LCD on, tile data at 8000, map at 9800, background on
`define PPU_LCDC_RESET      8'h91

`endif

// ==== verilog/ppu_pkg.sv ====
package ppu_pkg;

  // Encoded as the hardware mode number
  typedef enum logic [1:0] {
    PPU_MODE_0 = 2'd0,  // H-blank
    PPU_MODE_1 = 2'd1,  // V-blank
    PPU_MODE_2 = 2'd2,  // OAM scan
    PPU_MODE_3 = 2'd3   // Pixel transfer
  } ppu_mode_t;

  // Raw background colour index
  typedef logic [1:0] color_idx_t;

  // Shade after the BGP palette
  typedef logic [1:0] shade_t;

  // Background fetcher steps
  typedef enum logic [2:0] {
    FETCH_MAP,
    FETCH_LO,
    FETCH_HI,
    FETCH_PUSH,
    FETCH_IDLE
  } fetch_state_t;

endpackage

// ==== verilog/ppu_bus_regs.sv ====
`include "ppu_defs.svh"

module ppu_bus_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        addr,
  input  logic [7:0]         wdata,
  input  logic               write_en,
  input  logic               read_en,
  output logic [7:0]         rdata,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]         ly,
  input  logic [12:0]        vram_addr,
  output logic [7:0]         vram_rdata,
  output logic [7:0]         lcdc,
  output logic [7:0]         scy,
  output logic [7:0]         scx,
  output logic [7:0]         bgp
);
  import ppu_pkg::*;

  logic [7:0]  vram [0:`PPU_VRAM_LAST - `PPU_VRAM_BASE];
  logic        vram_sel;
  logic [12:0] vram_idx;
  logic        cpu_blocked;

  assign vram_sel    = (addr >= `PPU_VRAM_BASE) && (addr <= `PPU_VRAM_LAST);
  assign vram_idx    = 13'(addr - `PPU_VRAM_BASE);
  // CPU loses VRAM while the fetcher owns it
  assign cpu_blocked = (mode == PPU_MODE_3);

  // ======================================================================
  // VRAM
  // ======================================================================
  always_ff @(posedge clk) begin
    if (write_en && vram_sel && !cpu_blocked) begin
      vram[vram_idx] <= wdata;
    end
  end

  // Second port for the fetcher, never blocked
  assign vram_rdata = vram[vram_addr];

  // ======================================================================
  // Registers
  // ======================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc <= `PPU_LCDC_RESET;
      scy  <= 8'h00;
      scx  <= 8'h00;
      bgp  <= 8'h00;
    end else if (write_en) begin
      // LY is owned by the timer, writes to it fall through
      case (addr)
        `PPU_REG_LCDC: lcdc <= wdata;
        `PPU_REG_SCY:  scy  <= wdata;
        `PPU_REG_SCX:  scx  <= wdata;
        `PPU_REG_BGP:  bgp  <= wdata;
        default: ;
      endcase
    end
  end

  // Read mux, open bus reads FF
  always_comb begin
    rdata = 8'hFF;
    if (read_en) begin
      if (vram_sel) begin
        rdata = cpu_blocked ? 8'hFF : vram[vram_idx];
      end else begin
        case (addr)
          `PPU_REG_LCDC: rdata = lcdc;
          `PPU_REG_SCY:  rdata = scy;
          `PPU_REG_SCX:  rdata = scx;
          `PPU_REG_LY:   rdata = ly;
          `PPU_REG_BGP:  rdata = bgp;
          default:       rdata = 8'hFF;
        endcase
      end
    end
  end

  // Bus master issues one access at a time
  assert property (@(posedge clk) disable iff (reset) !(write_en && read_en));

  // Live line from the timer stays inside the frame
  assert property (@(posedge clk) disable iff (reset) ly < `PPU_LINES_PER_FRAME);

endmodule

// ==== verilog/ppu_mode_timer.sv ====
`include "ppu_defs.svh"

module ppu_mode_timer (
  input  logic               clk,
  input  logic               reset,
  input  logic               lcd_on,
  output ppu_pkg::ppu_mode_t mode,
  output logic [7:0]         ly,
  output logic               line_start,
  output logic               vblank_irq
);
  import ppu_pkg::*;

  logic [8:0] dot;
  logic       line_end;
  logic [7:0] ly_next;

  assign line_end = (dot == `PPU_DOTS_PER_LINE - 9'd1);
  assign ly_next  = (ly == `PPU_LINES_PER_FRAME - 8'd1) ? 8'd0 : ly + 8'd1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= 9'd0;
      ly         <= 8'd0;
      mode       <= PPU_MODE_2;
      line_start <= 1'b0;
      vblank_irq <= 1'b0;
    end else if (!lcd_on) begin
      // LCD off parks the timer at the top of the frame
      dot        <= 9'd0;
      ly         <= 8'd0;
      mode       <= PPU_MODE_2;
      line_start <= 1'b0;
      vblank_irq <= 1'b0;
    end else begin
      line_start <= 1'b0;
      vblank_irq <= 1'b0;
      if (line_end) begin
        dot <= 9'd0;
        ly  <= ly_next;
        if (ly_next >= `PPU_VISIBLE_LINES) begin
          mode <= PPU_MODE_1;
        end else begin
          mode <= PPU_MODE_2;
        end
        // One pulse on entry to the first blank line
        vblank_irq <= (ly_next == `PPU_VISIBLE_LINES);
      end else begin
        dot <= dot + 9'd1;
        if (mode != PPU_MODE_1) begin
          if (dot == `PPU_MODE2_LEN - 9'd1) begin
            mode       <= PPU_MODE_3;
            line_start <= 1'b1;
          end else if (dot == `PPU_MODE2_LEN + `PPU_MODE3_LEN - 9'd1) begin
            mode <= PPU_MODE_0;
          end
        end
      end
    end
  end

  // V-blank covers exactly the lines below the screen
  assert property (@(posedge clk) disable iff (reset)
    (mode == PPU_MODE_1) == (ly >= `PPU_VISIBLE_LINES));

endmodule

// ==== verilog/bg_fetcher.sv ====
`include "ppu_defs.svh"

module bg_fetcher (
  input  logic                      clk,
  input  logic                      reset,
  input  ppu_pkg::ppu_mode_t        mode,
  input  logic                      line_start,
  input  logic [7:0]                ly,
  input  logic [7:0]                scx,
  input  logic [7:0]                scy,
  input  logic [7:0]                lcdc,
  output logic [12:0]               vram_addr,
  input  logic [7:0]                vram_rdata,
  input  logic                      space,
  output logic                      push_en,
  output ppu_pkg::color_idx_t [7:0] push_px
);
  import ppu_pkg::*;

  fetch_state_t state;
  logic [4:0]   col;
  logic [7:0]   row;
  logic [7:0]   tile_num;
  logic [7:0]   data_lo;
  logic [7:0]   data_hi;
  logic [15:0]  map_addr;
  logic [15:0]  data_addr;
  logic         data_base_bit;

  // Map entry at 9800 or 9C00 with 32 tiles per row
  assign map_addr = {5'b10011, lcdc[3], row[7:3], col};

  // Signed mode puts tiles 0..127 at 9000 and 128..255 at 8800
  assign data_base_bit = lcdc[4] ? 1'b0 : ~tile_num[7];
  assign data_addr = {3'b100, data_base_bit, tile_num, row[2:0], state == FETCH_HI};

  assign vram_addr = 13'(((state == FETCH_MAP) ? map_addr : data_addr) - `PPU_VRAM_BASE);

  assign push_en = (state == FETCH_PUSH) && space;

  // Leftmost pixel sits in slot 0 and comes from bit 7
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_px[i] = {data_hi[7 - i], data_lo[7 - i]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= FETCH_IDLE;
      col   <= 5'd0;
      row   <= 8'd0;
    end else if (mode != PPU_MODE_3) begin
      state <= FETCH_IDLE;
    end else if (line_start) begin
      col   <= scx[7:3];
      row   <= ly + scy;
      state <= FETCH_MAP;
    end else begin
      case (state)
        FETCH_MAP:  state <= FETCH_LO;
        FETCH_LO:   state <= FETCH_HI;
        FETCH_HI:   state <= FETCH_PUSH;
        FETCH_PUSH: begin
          // Hold here until the FIFO has room for a whole tile
          if (space) begin
            col   <= col + 5'd1;
            state <= FETCH_MAP;
          end
        end
        default: ;
      endcase
    end
  end

  // Tile number and bitplanes
  always_ff @(posedge clk) begin
    case (state)
      FETCH_MAP: tile_num <= vram_rdata;
      FETCH_LO:  data_lo  <= vram_rdata;
      FETCH_HI:  data_hi  <= vram_rdata;
      default: ;
    endcase
  end

  // Pixel transfer always opens with a line_start pulse
  assert property (@(posedge clk) disable iff (reset)
    (mode == PPU_MODE_3 && !line_start) |-> (state != FETCH_IDLE));

endmodule

// ==== verilog/pixel_fifo.sv ====
module pixel_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      push_en,
  input  ppu_pkg::color_idx_t [7:0] push_px,
  output logic                      space,
  input  logic                      pop_en,
  output ppu_pkg::color_idx_t       top_px,
  output logic                      empty
);
  import ppu_pkg::*;

  color_idx_t mem [0:15];
  logic [3:0] rd_ptr;
  logic [3:0] wr_ptr;
  logic [4:0] count;

  // Room for one more tile
  assign space  = (count <= 5'd8);
  assign empty  = (count == 5'd0);
  assign top_px = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_en) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + 4'(i)] <= push_px[i];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= 4'd0;
      wr_ptr <= 4'd0;
      count  <= 5'd0;
    end else if (flush) begin
      rd_ptr <= 4'd0;
      wr_ptr <= 4'd0;
      count  <= 5'd0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 4'd8;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
      count <= count + (push_en ? 5'd8 : 5'd0) - (pop_en ? 5'd1 : 5'd0);
    end
  end

  // Fetcher must honour space
  assert property (@(posedge clk) disable iff (reset) push_en |-> (count <= 5'd8));

  // Output stage must watch empty
  assert property (@(posedge clk) disable iff (reset) pop_en |-> (count != 5'd0));

endmodule

// ==== verilog/pixel_output.sv ====
`include "ppu_defs.svh"

module pixel_output (
  input  logic                clk,
  input  logic                reset,
  input  logic                line_start,
  input  ppu_pkg::ppu_mode_t  mode,
  input  logic [7:0]          ly,
  input  logic [7:0]          scx,
  input  logic [7:0]          lcdc,
  input  logic [7:0]          bgp,
  input  logic                empty,
  input  ppu_pkg::color_idx_t top_px,
  output logic                pop_en,
  output logic                pixel_valid,
  output logic [7:0]          pixel_x,
  output logic [7:0]          pixel_y,
  output ppu_pkg::shade_t     pixel_shade
);
  import ppu_pkg::*;

  logic [7:0] x_count;
  logic [2:0] discard;
  logic       line_done;
  logic       keep;
  shade_t     shade;

  assign line_done = (x_count == `PPU_SCREEN_W);
  // The FIFO is being flushed on line_start
  assign pop_en = (mode == PPU_MODE_3) && !line_start && !empty && !line_done;
  assign keep   = pop_en && (discard == 3'd0);

  // BGP lookup, background disabled shows shade 0
  assign shade = lcdc[0] ? bgp[{top_px, 1'b0} +: 2] : 2'd0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_count     <= 8'd0;
      discard     <= 3'd0;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= keep;
      if (line_start) begin
        x_count <= 8'd0;
        discard <= scx[2:0];
      end else if (pop_en) begin
        // Fine scroll pixels are popped and dropped
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end else begin
          x_count <= x_count + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      pixel_x     <= x_count;
      pixel_y     <= ly;
      pixel_shade <= shade;
    end
  end

endmodule

// ==== verilog/ppu_top.sv ====
module ppu_top (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        addr,
  input  logic [7:0]         wdata,
  input  logic               write_en,
  input  logic               read_en,
  output logic [7:0]         rdata,
  output ppu_pkg::ppu_mode_t mode,
  output logic [7:0]         ly,
  output logic               vblank_irq,
  output logic               pixel_valid,
  output logic [7:0]         pixel_x,
  output logic [7:0]         pixel_y,
  output ppu_pkg::shade_t    pixel_shade
);
  import ppu_pkg::*;

  logic [7:0]       lcdc;
  logic [7:0]       scy;
  logic [7:0]       scx;
  logic [7:0]       bgp;
  logic [12:0]      vram_addr;
  logic [7:0]       vram_rdata;
  logic             line_start;
  logic             push_en;
  logic             space;
  logic             pop_en;
  logic             empty;
  color_idx_t [7:0] push_px;
  color_idx_t       top_px;

  // ======================================================================
  // CPU side
  // ======================================================================
  ppu_bus_regs u_bus_regs (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .wdata      (wdata),
    .write_en   (write_en),
    .read_en    (read_en),
    .rdata      (rdata),
    .mode       (mode),
    .ly         (ly),
    .vram_addr  (vram_addr),
    .vram_rdata (vram_rdata),
    .lcdc       (lcdc),
    .scy        (scy),
    .scx        (scx),
    .bgp        (bgp)
  );

  // ======================================================================
  // Timing and background pipeline
  // ======================================================================
  ppu_mode_timer u_mode_timer (
    .clk        (clk),
    .reset      (reset),
    .lcd_on     (lcdc[7]),
    .mode       (mode),
    .ly         (ly),
    .line_start (line_start),
    .vblank_irq (vblank_irq)
  );

  bg_fetcher u_bg_fetcher (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .line_start (line_start),
    .ly         (ly),
    .scx        (scx),
    .scy        (scy),
    .lcdc       (lcdc),
    .vram_addr  (vram_addr),
    .vram_rdata (vram_rdata),
    .space      (space),
    .push_en    (push_en),
    .push_px    (push_px)
  );

  pixel_fifo u_pixel_fifo (
    .clk     (clk),
    .reset   (reset),
    .flush   (line_start),
    .push_en (push_en),
    .push_px (push_px),
    .space   (space),
    .pop_en  (pop_en),
    .top_px  (top_px),
    .empty   (empty)
  );

  // ======================================================================
  // Output side
  // ======================================================================
  pixel_output u_pixel_output (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .mode        (mode),
    .ly          (ly),
    .scx         (scx),
    .lcdc        (lcdc),
    .bgp         (bgp),
    .empty       (empty),
    .top_px      (top_px),
    .pop_en      (pop_en),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_shade (pixel_shade)
  );

endmodule

// ==== verification/ppu_tb.sv ====
`include "ppu_defs.svh"

module ppu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ppu_pkg::*;

  logic        clk;
  logic        reset;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        write_en;
  logic        read_en;
  logic [7:0]  rdata;
  ppu_mode_t   mode;
  logic [7:0]  ly;
  logic        vblank_irq;
  logic        pixel_valid;
  logic [7:0]  pixel_x;
  logic [7:0]  pixel_y;
  shade_t      pixel_shade;

  integer seed = 71263;
  integer cycle = 0;
  integer limit = 0;
  integer lcd_mark = 0;
  integer event_mark = 0;

  // Parsed vector commands
  logic [7:0]  cmd_q [$];
  logic [31:0] a_q [$];
  logic [31:0] b_q [$];
  logic [31:0] c_q [$];

  // Random bytes written in the register test, by address
  logic [7:0] kept [logic [15:0]];

  // First pixel seen at each x since the last LCDC write
  logic       filled [0:255];
  logic [7:0] seen_line [0:255];
  shade_t     seen_shade [0:255];

  ppu_top UUT (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .write_en    (write_en),
    .read_en     (read_en),
    .rdata       (rdata),
    .mode        (mode),
    .ly          (ly),
    .vblank_irq  (vblank_irq),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_shade (pixel_shade)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ======================================================================
  // Failure handling and compare tasks
  // ======================================================================
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    if (cycle > limit) begin
      stop_run($sformatf("Timeout after %0d cycles, the run did not finish", cycle));
    end
  end

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0d ns: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_shade(input shade_t got, input shade_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_mode(input ppu_mode_t got, input ppu_mode_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0d ns: %s, got mode %0d, expected mode %0d",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_count(input integer got, input integer exp, input string what);
    if (got != exp) begin
      stop_run($sformatf("Fail at %0d ns: %s, got %0d cycles, expected %0d",
                         $time, what, got, exp));
    end
  endtask

  // ======================================================================
  // Bus driver and monitors
  // ======================================================================
  // Advance to the drive point 5 ns after the next rising edge
  task automatic step_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    addr     = a;
    wdata    = d;
    write_en = 1'b1;
    step_cycle();
    write_en = 1'b0;
  endtask

  // rdata is combinational, sampled mid cycle
  task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
    addr    = a;
    read_en = 1'b1;
    #10;
    d = rdata;
    step_cycle();
    read_en = 1'b0;
  endtask

  task automatic clear_pixels();
    integer i;
    for (i = 0; i < 256; i = i + 1) begin
      filled[i] = 1'b0;
    end
  endtask

  always @(negedge clk) begin
    if (pixel_valid && !filled[pixel_x]) begin
      filled[pixel_x]     = 1'b1;
      seen_line[pixel_x]  = pixel_y;
      seen_shade[pixel_x] = pixel_shade;
    end
  end

  task automatic wait_mode(input ppu_mode_t want, input integer max_cycles);
    integer waited;
    waited = 0;
    while (mode != want) begin
      if (waited >= max_cycles) begin
        stop_run($sformatf("Timed out after %0d cycles waiting for mode %0d", waited, want));
      end else begin
        step_cycle();
        waited = waited + 1;
      end
    end
  endtask

  task automatic wait_pixel(input logic [7:0] x);
    while (!filled[x]) begin
      step_cycle();
    end
  endtask

  // ======================================================================
  // Vector file
  // ======================================================================
  task automatic load_vectors();
    integer      fd;
    integer      n;
    string       line;
    logic [7:0]  c;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    fd = $fopen("verification/ppu_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open verification/ppu_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", c, f1, f2, f3);
          if (n != 4) begin
            stop_run({"Malformed vector line: ", line});
          end else begin
            cmd_q.push_back(c);
            a_q.push_back(f1);
            b_q.push_back(f2);
            c_q.push_back(f3);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_command(input logic [7:0] c, input logic [31:0] f1,
                             input logic [31:0] f2, input logic [31:0] f3);
    logic [7:0] data;
    logic [7:0] got;
    logic [7:0] exp;
    integer     rnd;
    case (c)
      "W": begin
        data = f2[7:0];
        // Flagged writes carry a random byte instead of the file data
        if (f3[0]) begin
          rnd  = $random(seed);
          data = rnd[7:0];
          kept[f1[15:0]] = data;
        end
        bus_write(f1[15:0], data);
        if (f1[15:0] == `PPU_REG_LCDC) begin
          lcd_mark = cycle;
          clear_pixels();
        end
      end
      "R": begin
        bus_read(f1[15:0], got);
        exp = f3[0] ? kept[f1[15:0]] : f2[7:0];
        check_byte(got, exp, $sformatf("read of %h", f1[15:0]));
      end
      "M": begin
        wait_mode(ppu_mode_t'(f1[1:0]), f3);
        if (f2 != 0) begin
          check_count(cycle - event_mark, f2, $sformatf("cycles to mode %0d", f1[1:0]));
        end
        event_mark = cycle;
      end
      "P": begin
        wait_pixel(f2[7:0]);
        check_byte(seen_line[f2[7:0]], f1[7:0], $sformatf("line of pixel x %0d", f2[7:0]));
        check_shade(seen_shade[f2[7:0]], shade_t'(f3[1:0]),
                    $sformatf("shade at line %0d x %0d", f1[7:0], f2[7:0]));
      end
      "V": begin
        while (!vblank_irq) begin
          step_cycle();
        end
        check_count(cycle - lcd_mark, f1, "cycles from LCD on to V-blank");
        check_byte(ly, f2[7:0], "ly at V-blank");
        check_mode(mode, ppu_mode_t'(f3[1:0]), "mode at V-blank");
        event_mark = cycle;
      end
      default: begin
        stop_run($sformatf("Unknown vector command '%c'", c));
      end
    endcase
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    integer idx;
    addr     = 16'h0000;
    wdata    = 8'h00;
    write_en = 1'b0;
    read_en  = 1'b0;
    reset    = 1'b1;
    clear_pixels();
    load_vectors();
    // Three frames plus slack for every command
    limit = 3 * `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME + 200 * cmd_q.size();
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    for (idx = 0; idx < cmd_q.size(); idx = idx + 1) begin
      run_command(cmd_q[idx], a_q[idx], b_q[idx], c_q[idx]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/ppu_pkg.sv
verilog/ppu_bus_regs.sv
verilog/ppu_mode_timer.sv
verilog/bg_fetcher.sv
verilog/pixel_fifo.sv
verilog/pixel_output.sv
verilog/ppu_top.sv
verification/ppu_tb.sv

// ==== Makefile ====
SIM      = verilator
VFLAGS   = --binary --timing --assert --timescale 1ns/1ps
TOP      = ppu_tb
FILELIST = project.f

BIN     = obj_dir/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== verification/ppu_vectors.txt ====
# W addr data rnd | R addr expect rnd | M mode cycles timeout | P line x shade
# V cycles ly mode  (all fields hex, rnd 1 uses a random byte kept by the testbench)
# Registers and VRAM with the LCD off
W FF40 11 0
W 8000 00 1
W 9FFF 00 1
W FF43 00 1
W FF42 00 1
W FF47 00 1
R 8000 00 1
R 9FFF 00 1
R FF43 00 1
R FF42 00 1
R FF47 00 1
R FF40 11 0
W FF44 55 0
R FF44 00 0
R FF41 FF 0
# Mode 3 blocks CPU access to VRAM
W FF40 91 0
M 3 0 C8
R 8000 FF 0
W 8000 5A 0
M 0 0 C8
R 8000 00 1
# Frame timing from the LCD on write above
V 10080 90 1
R FF44 90 0
M 2 11D0 1400
R FF44 00 0
# Tile data at 8000, map at 9800, BGP 1B
W FF40 11 0
W FF43 00 0
W FF42 00 0
W FF47 1B 0
W 9800 01 0
W 9801 01 0
W 8010 55 0
W 8011 33 0
W FF40 91 0
P 0 0 3
P 0 1 2
P 0 2 1
P 0 3 0
P 0 6 1
P 0 8 3
# SCX 3, SCY 8, map at 9C00, signed tile data, BGP D2
W FF40 11 0
W FF43 03 0
W FF42 08 0
W FF47 D2 0
W 9C20 80 0
W 9C21 01 0
W 8800 0F 0
W 8801 3C 0
W 9010 80 0
W 9011 80 0
W FF40 89 0
P 0 0 1
P 0 1 3
P 0 4 0
P 0 5 3
P 0 6 2
# Background off gives shade 0
W FF40 08 0
R FF40 08 0
W FF40 88 0
P 0 0 0
P 0 5 0
